// File: fetch_pkg.sv
package fetch_pkg;

	parameter int addr_w = 32; // byte address width.
	parameter int data_w = 32; // instruction word width.

	parameter int line_words = 4; // words per cache line.
	parameter int off_w = $clog2(line_words) + 2; // byte offset inside a line.

	// cacheable SDRAM window, base inclusive and limit exclusive.
	parameter logic [addr_w-1:0] sdram_base  = 32'ha000_0000;
	parameter logic [addr_w-1:0] sdram_limit = 32'ha200_0000;

	parameter logic [1:0] resp_okay = 2'b00;
	parameter logic [1:0] resp_miss = 2'b10; // bit 1 flags a cache miss.

	parameter logic [1:0] burst_fixed = 2'b00;
	parameter logic [1:0] burst_incr  = 2'b01;

	parameter logic [3:0] beats_line = 4'd3; // arlen of one line refill.

endpackage

// File: storage_array.sv
`timescale 1ns/1ps

module storage_array #(
	parameter type elem_t = logic,
	parameter int  depth  = 16
) (
	input  logic                     clock,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  elem_t                    wdata,
	input  logic [$clog2(depth)-1:0] raddr,
	output elem_t                    rdata
);

	elem_t mem [depth]; // plain registers, no reset.

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr]; // read is combinational.

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int index_w = 4
) (
	input  logic                         clock,
	input  logic                         rst_n,

	input  logic [fetch_pkg::addr_w-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [fetch_pkg::data_w-1:0] rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,

	input  logic [fetch_pkg::addr_w-1:0] awaddr,
	input  logic                         awvalid,
	input  logic [fetch_pkg::data_w-1:0] wdata,
	input  logic                         wvalid,
	output logic                         awready,
	output logic                         wready,
	output logic                         bvalid,
	input  logic                         bready
);

	localparam int lines  = 1 << index_w;
	localparam int word_w = fetch_pkg::off_w - 2;
	localparam int tag_w  = fetch_pkg::addr_w - index_w - fetch_pkg::off_w;

	typedef logic [tag_w-1:0] tag_t;
	typedef logic [fetch_pkg::line_words-1:0][fetch_pkg::data_w-1:0] line_t;

	logic               ar_hs;
	logic               w_hs;
	logic               last_word;
	logic               hit;
	logic [index_w-1:0] rd_idx;
	logic [index_w-1:0] wr_idx;
	logic [index_w-1:0] data_raddr;
	logic [word_w-1:0]  rd_word;
	logic [word_w-1:0]  wr_word;
	tag_t               rd_tag;
	tag_t               wr_tag;
	tag_t               tag_q;
	line_t              line_q;
	line_t              line_new;
	logic [lines-1:0]   valid_q;

	assign arready = 1'b1; // lookups never stall.
	assign ar_hs   = arvalid & arready;

	assign awready = awvalid & wvalid; // address and data are taken as a pair.
	assign wready  = awvalid & wvalid;
	assign w_hs    = awvalid & wvalid;

	assign rd_idx  = araddr[fetch_pkg::off_w +: index_w];
	assign rd_tag  = araddr[fetch_pkg::addr_w-1 -: tag_w];
	assign rd_word = araddr[fetch_pkg::off_w-1:2];
	assign wr_idx  = awaddr[fetch_pkg::off_w +: index_w];
	assign wr_tag  = awaddr[fetch_pkg::addr_w-1 -: tag_w];
	assign wr_word = awaddr[fetch_pkg::off_w-1:2];

	assign last_word  = (wr_word == word_w'(fetch_pkg::line_words - 1));
	assign data_raddr = w_hs ? wr_idx : rd_idx; // refill reads the line it merges into.
	assign hit        = valid_q[rd_idx] && (tag_q == rd_tag);

	// one refill word replaces its slot, the rest of the line is kept.
	always_comb begin
		line_new = line_q;
		line_new[wr_word] = wdata;
	end

	storage_array #(
		.elem_t(tag_t),
		.depth (lines)
	) u_tags (
		.clock(clock),
		.we   (w_hs & last_word),
		.waddr(wr_idx),
		.wdata(wr_tag),
		.raddr(rd_idx),
		.rdata(tag_q)
	);

	storage_array #(
		.elem_t(line_t),
		.depth (lines)
	) u_lines (
		.clock(clock),
		.we   (w_hs),
		.waddr(wr_idx),
		.wdata(line_new),
		.raddr(data_raddr),
		.rdata(line_q)
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			if (w_hs) begin
				valid_q[wr_idx] <= last_word; // line stays invalid until fully refilled.
			end
			rvalid <= ar_hs | (rvalid & ~rready);
			bvalid <= w_hs | (bvalid & ~bready);
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			rdata <= line_q[rd_word];
			rresp <= hit ? fetch_pkg::resp_okay : fetch_pkg::resp_miss;
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		$rose(awvalid) == $rose(wvalid));

	assert property (@(posedge clock) disable iff (!rst_n)
		rvalid && rready |=> !rvalid);

endmodule

// File: ifu.sv
`timescale 1ns/1ps

module ifu (
	input  logic                         clock,
	input  logic                         rst_n,

	input  logic                         wb_valid,
	input  logic [fetch_pkg::addr_w-1:0] pc,
	output logic [fetch_pkg::data_w-1:0] inst,
	output logic                         idu_valid,

	output logic [fetch_pkg::addr_w-1:0] mem_araddr,
	output logic                         mem_arvalid,
	input  logic                         mem_arready,
	output logic [1:0]                   mem_arburst,
	output logic [3:0]                   mem_arlen,
	input  logic [fetch_pkg::data_w-1:0] mem_rdata,
	input  logic [1:0]                   mem_rresp,
	input  logic                         mem_rvalid,
	output logic                         mem_rready,

	output logic [fetch_pkg::addr_w-1:0] icache_araddr,
	output logic                         icache_arvalid,
	input  logic                         icache_arready,
	input  logic [fetch_pkg::data_w-1:0] icache_rdata,
	input  logic [1:0]                   icache_rresp,
	input  logic                         icache_rvalid,
	output logic                         icache_rready,

	output logic [fetch_pkg::addr_w-1:0] icache_awaddr,
	output logic                         icache_awvalid,
	input  logic                         icache_awready,
	output logic [fetch_pkg::data_w-1:0] icache_wdata,
	output logic                         icache_wvalid,
	input  logic                         icache_wready,
	input  logic                         icache_bvalid,
	output logic                         icache_bready
);

	localparam int cnt_w = $clog2(fetch_pkg::line_words) + 1;

	logic [fetch_pkg::addr_w-1:0] pc_q;
	logic [fetch_pkg::addr_w-1:0] line_base;
	logic                         start_q;
	logic                         cached;
	logic                         hit_hs;
	logic                         miss_hs;
	logic                         ar_hs;
	logic                         r_hs;
	logic                         wr_hs;
	logic                         b_hs;
	logic                         wr_valid_q;
	logic [cnt_w-1:0]             count_q;
	logic                         take_mem;
	logic                         done;

	assign cached    = (pc_q >= fetch_pkg::sdram_base) && (pc_q < fetch_pkg::sdram_limit);
	assign line_base = {pc_q[fetch_pkg::addr_w-1:fetch_pkg::off_w], {fetch_pkg::off_w{1'b0}}};

	assign mem_araddr  = cached ? line_base : pc_q;
	assign mem_arburst = cached ? fetch_pkg::burst_incr : fetch_pkg::burst_fixed;
	assign mem_arlen   = cached ? fetch_pkg::beats_line : 4'd0;

	assign icache_araddr  = pc_q;
	assign icache_rready  = 1'b1;
	assign icache_bready  = 1'b1;
	assign icache_awvalid = wr_valid_q; // address and data travel as one refill word.
	assign icache_wvalid  = wr_valid_q;

	assign hit_hs  = icache_rvalid & icache_rready & ~icache_rresp[1];
	assign miss_hs = icache_rvalid & icache_rready & icache_rresp[1];
	assign ar_hs   = mem_arvalid & mem_arready;
	assign r_hs    = mem_rvalid & mem_rready;
	assign wr_hs   = wr_valid_q & icache_awready & icache_wready;
	assign b_hs    = icache_bvalid & icache_bready;

	// keep the beat whose word offset matches the pc.
	assign take_mem = r_hs &
		(~cached | (icache_awaddr[fetch_pkg::off_w-1:2] == pc_q[fetch_pkg::off_w-1:2]));

	assign done = hit_hs | (b_hs & (count_q == '0)) | (r_hs & ~cached);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			start_q        <= 1'b0;
			icache_arvalid <= 1'b0;
			mem_arvalid    <= 1'b0;
			mem_rready     <= 1'b1;
			wr_valid_q     <= 1'b0;
			count_q        <= '0;
			idu_valid      <= 1'b0;
			inst           <= '0;
		end else begin
			start_q        <= wb_valid;
			icache_arvalid <= (icache_arvalid & ~icache_arready) | (start_q & cached);
			mem_arvalid    <= (mem_arvalid & ~mem_arready) | miss_hs | (start_q & ~cached);
			wr_valid_q     <= (wr_valid_q & ~wr_hs) | (r_hs & cached);
			idu_valid      <= done;

			// hold the next beat back while a refill write is in the cache.
			if (r_hs && cached) begin
				mem_rready <= 1'b0;
			end else if (b_hs) begin
				mem_rready <= 1'b1;
			end

			if (ar_hs && cached) begin
				count_q <= cnt_w'(fetch_pkg::line_words);
			end else if (r_hs && cached) begin
				count_q <= count_q - 1'b1; // beats still to come.
			end

			if (take_mem) begin
				inst <= mem_rdata;
			end else if (hit_hs) begin
				inst <= icache_rdata;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wb_valid) begin
			pc_q <= pc;
		end
		if (r_hs) begin
			icache_wdata <= mem_rdata;
		end
		if (miss_hs) begin
			icache_awaddr <= line_base;
		end else if (b_hs) begin
			icache_awaddr <= icache_awaddr + 4; // next word of the line.
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

	assert property (@(posedge clock) disable iff (!rst_n)
		idu_valid |=> !idu_valid);

	// instruction memory is expected to answer every beat without error.
	assert property (@(posedge clock) disable iff (!rst_n)
		r_hs |-> mem_rresp == fetch_pkg::resp_okay);

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter int index_w = 4
) (
	input  logic                         clock,
	input  logic                         rst_n,

	input  logic                         wb_valid,
	input  logic [fetch_pkg::addr_w-1:0] pc,
	output logic [fetch_pkg::data_w-1:0] inst,
	output logic                         idu_valid,

	output logic [fetch_pkg::addr_w-1:0] mem_araddr,
	output logic                         mem_arvalid,
	input  logic                         mem_arready,
	output logic [1:0]                   mem_arburst,
	output logic [3:0]                   mem_arlen,
	input  logic [fetch_pkg::data_w-1:0] mem_rdata,
	input  logic [1:0]                   mem_rresp,
	input  logic                         mem_rvalid,
	output logic                         mem_rready
);

	logic [fetch_pkg::addr_w-1:0] ic_araddr;
	logic                         ic_arvalid;
	logic                         ic_arready;
	logic [fetch_pkg::data_w-1:0] ic_rdata;
	logic [1:0]                   ic_rresp;
	logic                         ic_rvalid;
	logic                         ic_rready;
	logic [fetch_pkg::addr_w-1:0] ic_awaddr;
	logic                         ic_awvalid;
	logic                         ic_awready;
	logic [fetch_pkg::data_w-1:0] ic_wdata;
	logic                         ic_wvalid;
	logic                         ic_wready;
	logic                         ic_bvalid;
	logic                         ic_bready;

	ifu u_ifu (
		.clock         (clock),
		.rst_n         (rst_n),
		.wb_valid      (wb_valid),
		.pc            (pc),
		.inst          (inst),
		.idu_valid     (idu_valid),
		.mem_araddr    (mem_araddr),
		.mem_arvalid   (mem_arvalid),
		.mem_arready   (mem_arready),
		.mem_arburst   (mem_arburst),
		.mem_arlen     (mem_arlen),
		.mem_rdata     (mem_rdata),
		.mem_rresp     (mem_rresp),
		.mem_rvalid    (mem_rvalid),
		.mem_rready    (mem_rready),
		.icache_araddr (ic_araddr),
		.icache_arvalid(ic_arvalid),
		.icache_arready(ic_arready),
		.icache_rdata  (ic_rdata),
		.icache_rresp  (ic_rresp),
		.icache_rvalid (ic_rvalid),
		.icache_rready (ic_rready),
		.icache_awaddr (ic_awaddr),
		.icache_awvalid(ic_awvalid),
		.icache_awready(ic_awready),
		.icache_wdata  (ic_wdata),
		.icache_wvalid (ic_wvalid),
		.icache_wready (ic_wready),
		.icache_bvalid (ic_bvalid),
		.icache_bready (ic_bready)
	);

	icache #(
		.index_w(index_w)
	) u_icache (
		.clock  (clock),
		.rst_n  (rst_n),
		.araddr (ic_araddr),
		.arvalid(ic_arvalid),
		.arready(ic_arready),
		.rdata  (ic_rdata),
		.rresp  (ic_rresp),
		.rvalid (ic_rvalid),
		.rready (ic_rready),
		.awaddr (ic_awaddr),
		.awvalid(ic_awvalid),
		.wdata  (ic_wdata),
		.wvalid (ic_wvalid),
		.awready(ic_awready),
		.wready (ic_wready),
		.bvalid (ic_bvalid),
		.bready (ic_bready)
	);

endmodule

// File: tb_mem.sv
`timescale 1ns/1ps

module tb_mem (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic [fetch_pkg::addr_w-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	input  logic [1:0]                   arburst,
	input  logic [3:0]                   arlen,
	output logic [fetch_pkg::addr_w-1:0] beat_addr,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready
);

	logic       busy;
	logic [3:0] beats_left;
	logic [1:0] burst_q;
	logic [1:0] delay;

	assign rresp = fetch_pkg::resp_okay;

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			busy       <= 1'b0;
			beats_left <= '0;
			burst_q    <= fetch_pkg::burst_fixed;
			delay      <= '0;
			beat_addr  <= '0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				busy       <= 1'b1;
				arready    <= 1'b0;
				beat_addr  <= araddr;
				beats_left <= arlen; // arlen counts beats minus one.
				burst_q    <= arburst;
				delay      <= 2'($urandom);
			end else begin
				arready <= ($urandom % 3) != 0; // ready about two cycles in three.
			end
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
				delay  <= 2'($urandom);
				if (beats_left == '0) begin
					busy <= 1'b0;
				end else begin
					beats_left <= beats_left - 4'd1;
					if (burst_q == fetch_pkg::burst_incr) begin
						beat_addr <= beat_addr + 4;
					end
				end
			end
		end else if (delay == '0) begin
			rvalid <= 1'b1; // beat holds until rready.
		end else begin
			delay <= delay - 2'd1;
		end
	end

endmodule

// File: tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

	localparam int index_w      = 4;
	localparam int lines        = 1 << index_w;
	localparam int tag_w        = fetch_pkg::addr_w - index_w - fetch_pkg::off_w;
	localparam int reset_cycles = 5;
	localparam int n_directed   = 13;
	localparam int n_random     = 200;
	localparam int cycle_limit  = (n_directed + n_random) * 40 + reset_cycles;

	logic                         clock = 1'b0;
	logic                         rst_n;
	logic                         wb_valid;
	logic [fetch_pkg::addr_w-1:0] pc;
	logic [fetch_pkg::data_w-1:0] inst;
	logic                         idu_valid;
	logic [fetch_pkg::addr_w-1:0] mem_araddr;
	logic                         mem_arvalid;
	logic                         mem_arready;
	logic [1:0]                   mem_arburst;
	logic [3:0]                   mem_arlen;
	logic [fetch_pkg::addr_w-1:0] beat_addr;
	logic [fetch_pkg::data_w-1:0] mem_rdata;
	logic [1:0]                   mem_rresp;
	logic                         mem_rvalid;
	logic                         mem_rready;

	logic [tag_w-1:0]             model_tag [lines];
	logic                         model_valid [lines];
	logic                         req_pending = 1'b0;
	logic                         req_line = 1'b0;
	logic                         line_burst = 1'b0;
	logic                         after_beat = 1'b0;
	logic                         exp_hit = 1'b0;
	logic                         fetch_hit = 1'b0;
	logic [fetch_pkg::addr_w-1:0] exp_araddr = '0;
	logic [fetch_pkg::addr_w-1:0] fetch_pc = '0;
	logic [3:0]                   exp_arlen = '0;
	int                           cycle = 0;
	int                           wb_cycle = 0;
	int                           ar_count = 0;
	int                           n_miss = 0;
	int                           n_uncached = 0;
	int                           n_done = 0;

	always #50 clock = ~clock;

	fetch_top #(
		.index_w(index_w)
	) u_dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.wb_valid   (wb_valid),
		.pc         (pc),
		.inst       (inst),
		.idu_valid  (idu_valid),
		.mem_araddr (mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_arburst(mem_arburst),
		.mem_arlen  (mem_arlen),
		.mem_rdata  (mem_rdata),
		.mem_rresp  (mem_rresp),
		.mem_rvalid (mem_rvalid),
		.mem_rready (mem_rready)
	);

	tb_mem u_mem (
		.clock    (clock),
		.rst_n    (rst_n),
		.araddr   (mem_araddr),
		.arvalid  (mem_arvalid),
		.arready  (mem_arready),
		.arburst  (mem_arburst),
		.arlen    (mem_arlen),
		.beat_addr(beat_addr),
		.rresp    (mem_rresp),
		.rvalid   (mem_rvalid),
		.rready   (mem_rready)
	);

	assign mem_rdata = mem_word(beat_addr);

	// fixed scramble of the address, odd multiplier keeps words distinct.
	function automatic logic [fetch_pkg::data_w-1:0] mem_word(
		input logic [fetch_pkg::addr_w-1:0] addr
	);
		return (addr * 32'h9e37_79b1) ^ {addr[12:0], addr[31:13]} ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic in_window(input logic [fetch_pkg::addr_w-1:0] addr);
		return (addr >= fetch_pkg::sdram_base) && (addr < fetch_pkg::sdram_limit);
	endfunction

	function automatic logic [fetch_pkg::addr_w-1:0] pick_base(input int sel);
		case (sel)
			0:       return 32'ha000_0000;
			1:       return 32'ha000_0010;
			2:       return 32'ha000_1000; // same index as line 0.
			3:       return 32'ha000_1010; // same index as line 1.
			4:       return 32'ha1ff_fff0;
			default: return 32'h0000_2000; // outside the window.
		endcase
	endfunction

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1);
	endtask

	// predict the memory traffic from the cache model, then issue the fetch.
	task automatic run_fetch(input logic [fetch_pkg::addr_w-1:0] addr);
		logic [index_w-1:0] idx;
		logic [tag_w-1:0]   tag;
		idx = addr[fetch_pkg::off_w +: index_w];
		tag = addr[fetch_pkg::addr_w-1 -: tag_w];
		exp_hit = 1'b0;
		if (!in_window(addr)) begin
			req_pending = 1'b1;
			req_line    = 1'b0;
			exp_araddr  = addr;
			exp_arlen   = 4'd0;
			n_uncached++;
		end else if (model_valid[idx] && model_tag[idx] == tag) begin
			req_pending = 1'b0;
			exp_hit     = 1'b1;
		end else begin
			req_pending = 1'b1;
			req_line    = 1'b1;
			exp_araddr  = {addr[fetch_pkg::addr_w-1:fetch_pkg::off_w], 4'h0};
			exp_arlen   = fetch_pkg::beats_line;
			model_valid[idx] = 1'b1;
			model_tag[idx]   = tag;
			n_miss++;
		end
		wb_valid <= 1'b1;
		pc       <= addr;
		@(posedge clock);
		wb_valid <= 1'b0;
		do begin
			@(posedge clock);
		end while (!idu_valid);
		assert (!req_pending) else begin
			$display("no memory request was seen for the fetch of pc %h", addr);
			stop_on_error();
		end
		repeat ($urandom % 3) @(posedge clock);
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: fetch unit gave no answer within %0d cycles", cycle_limit);
			stop_on_error();
		end
	end

	// every ar handshake must be one the model predicted.
	always @(posedge clock) begin
		if (rst_n && mem_arvalid && mem_arready) begin
			ar_count++;
			assert (req_pending) else begin
				$display("unexpected memory request at address %h", mem_araddr);
				stop_on_error();
			end
			assert (mem_araddr == exp_araddr && mem_arlen == exp_arlen &&
				(!req_line || mem_arburst == fetch_pkg::burst_incr)) else begin
				$display("mismatch at %0t: request %h len %0d burst %0d, expected %h len %0d",
					$time, mem_araddr, mem_arlen, mem_arburst, exp_araddr, exp_arlen);
				stop_on_error();
			end
			req_pending = 1'b0;
			line_burst  = req_line;
		end
		// the next refill beat waits while the cache write is pending.
		if (after_beat) begin
			assert (!mem_rready) else begin
				$display("mismatch at %0t: mem_rready high after a refill beat", $time);
				stop_on_error();
			end
		end
		after_beat <= rst_n && mem_rvalid && mem_rready && line_burst;
	end

	always @(posedge clock) begin
		if (rst_n && wb_valid) begin
			fetch_pc  = pc;
			fetch_hit = exp_hit;
			wb_cycle  = cycle;
		end
		if (rst_n && idu_valid) begin
			n_done++;
			assert (inst == mem_word(fetch_pc)) else begin
				$display("mismatch at %0t: pc %h gave %h, expected %h",
					$time, fetch_pc, inst, mem_word(fetch_pc));
				stop_on_error();
			end
			if (fetch_hit) begin
				assert (cycle - wb_cycle == 4) else begin
					$display("mismatch at %0t: hit on pc %h took %0d cycles, expected 4",
						$time, fetch_pc, cycle - wb_cycle);
					stop_on_error();
				end
			end
		end
	end

	initial begin
		int sel;
		int word;
		void'($urandom(3));
		rst_n    = 1'b0;
		wb_valid = 1'b0;
		pc       = '0;
		for (int i = 0; i < lines; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end
		repeat (reset_cycles) @(posedge clock);
		rst_n <= 1'b1;
		repeat (3) begin
			@(posedge clock);
			assert (!mem_arvalid && !idu_valid && inst == '0) else begin
				$display("mismatch at %0t: outputs active before the first fetch", $time);
				stop_on_error();
			end
		end

		// uncached pcs far from and just outside the window.
		run_fetch(32'h0000_1004);
		run_fetch(32'h9fff_fffc);
		run_fetch(32'ha200_0000);
		// first touch refills the line, then each word hits.
		run_fetch(32'ha000_0008);
		run_fetch(32'ha000_0000);
		run_fetch(32'ha000_0004);
		run_fetch(32'ha000_000c);
		run_fetch(32'ha000_0008);
		// same index with another tag, so each fetch evicts the other.
		run_fetch(32'ha000_1008);
		run_fetch(32'ha000_0008);
		run_fetch(32'ha000_1000);
		run_fetch(32'ha000_0004);
		run_fetch(32'ha1ff_fffc); // last word of the window.

		for (int i = 0; i < n_random; i++) begin
			sel  = $urandom % 6;
			word = $urandom % fetch_pkg::line_words;
			run_fetch(pick_base(sel) + 32'(word * 4));
		end
		@(posedge clock);

		assert (ar_count == n_miss + n_uncached) else begin
			$display("mismatch at %0t: %0d memory requests, expected %0d",
				$time, ar_count, n_miss + n_uncached);
			stop_on_error();
		end
		assert (n_done == n_directed + n_random) else begin
			$display("mismatch at %0t: %0d fetches answered, expected %0d",
				$time, n_done, n_directed + n_random);
			stop_on_error();
		end
		$display("Test passed");
		$finish;
	end

endmodule

// File: project.f
fetch_pkg.sv
storage_array.sv
icache.sv
ifu.sv
fetch_top.sv
tb_mem.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run, success only when the pass message shows up
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f project.f \
	&& ./obj_dir/Vtb_fetch | tee /dev/stderr | grep -q "Test passed" \
	&& echo "simulation finished ok" \
	|| { echo "simulation did not pass"; exit 1; }
